/* src/iq_macros.svh */
/*
 * Issue slice build constants
 * Queue sizing, data width and one-bit truth values
 */
`ifndef IQ_MACROS_SVH
`define IQ_MACROS_SVH

// Number of issue queue entries
`define QENTRIES 8
// Bits needed to index one queue entry
`define QNDX_W 3
// Width of operands and results
`define DATA_W 32

`define TRUE 1'b1
`define FALSE 1'b0

`endif

/* src/iq_pkg.sv */
/*
 * Issue slice package
 * Opcodes, queue entry layout and execute stage payloads
 */
`include "iq_macros.svh"

package iq_pkg;

	// ====================
	// Opcodes
	// ====================

	// Command register bits 2:0, codes 6 and 7 are unused
	typedef enum logic [2:0] {
		OP_NOP  = 3'd0,
		OP_SYNC = 3'd1,
		OP_FNEG = 3'd2,
		OP_FABS = 3'd3,
		OP_FMIN = 3'd4,
		OP_FMAX = 3'd5
	} iq_op_t;

	// ====================
	// Queue types
	// ====================

	typedef logic [`QNDX_W-1:0] que_ndx_t;
	typedef logic [`QENTRIES-1:0] que_bitmask_t;

	// One issue queue slot as seen by the selector
	typedef struct packed {
		logic v;
		logic fpu;
		logic sync;
		logic issued;
		logic done;
		iq_op_t op;
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		logic [`DATA_W-1:0] res;
	} iq_entry_t;

	// ====================
	// Execute payloads
	// ====================

	// Stage 1 keeps the operands and the precomputed total-order compare
	typedef struct packed {
		que_ndx_t ndx;
		iq_op_t op;
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		logic a_lt_b;
	} fpu_s1_t;

	// Stage 2 holds the finished result waiting for writeback
	typedef struct packed {
		que_ndx_t ndx;
		logic [`DATA_W-1:0] res;
	} fpu_s2_t;

endpackage

/* src/iq_intf.sv */
/*
 * Issue and writeback handshakes between queue, selector and FPU
 */
`timescale 1ns/1ps
`include "iq_macros.svh"

// Issue path, the selector picks and the queue supplies the operands
interface fpu_issue_if;
	import iq_pkg::*;

	logic valid;
	que_ndx_t ndx;
	iq_op_t op;
	logic [`DATA_W-1:0] a;
	logic [`DATA_W-1:0] b;
	// High while stage 1 of the FPU can take a new entry
	logic ready;

	modport sel (output valid, output ndx, input ready);
	modport exe (input valid, input ndx, input op, input a, input b, output ready);
	// Queue reads the index and marks the entry issued on a fire
	modport src (input valid, input ndx, input ready, output op, output a, output b);
endinterface

// Writeback path from the last FPU stage into the queue RAM
interface fpu_wb_if;
	import iq_pkg::*;

	logic valid;
	que_ndx_t ndx;
	logic [`DATA_W-1:0] res;
	// Low while dispatch owns the single RAM write port
	logic accept;

	modport exe (output valid, output ndx, output res, input accept);
	modport queue (input valid, input ndx, input res, output accept);
endinterface

/* src/iq_dispatch.sv */
/*
 * Dispatch, a Wishbone classic slave that collects operands
 * and pushes one command into the issue queue per command write
 */
`timescale 1ns/1ps
`include "iq_macros.svh"

module iq_dispatch (
	input  logic clk,
	input  logic arst_n,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [1:0] wb_adr,
	input  logic [`DATA_W-1:0] wb_dat_i,
	output logic wb_ack,
	input  logic full,
	output logic push,
	output iq_pkg::iq_op_t push_op,
	output logic [`DATA_W-1:0] push_a,
	output logic [`DATA_W-1:0] push_b
);
	import iq_pkg::*;

	logic go;
	logic cmd_wr;
	logic cmd_go;

	// A new bus request, ack being low keeps one ack per strobe
	assign go = wb_cyc & wb_stb & ~wb_ack;
	assign cmd_wr = wb_we & (wb_adr == 2'd2);
	// Command is taken only while the queue has room
	assign cmd_go = go & cmd_wr & ~full;

	// Push rides along with ack so the queue writes on the ack edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack <= `FALSE;
			push <= `FALSE;
		end else begin
			wb_ack <= go & (~cmd_wr | ~full);
			push <= cmd_go;
		end
	end

	// Operand registers and the latched opcode
	always_ff @(posedge clk) begin
		if (go & wb_we & (wb_adr == 2'd0))
			push_a <= wb_dat_i;
		if (go & wb_we & (wb_adr == 2'd1))
			push_b <= wb_dat_i;
		// Unused opcodes are retired as NOP
		if (cmd_go)
			push_op <= (wb_dat_i[2:0] > OP_FMAX) ? OP_NOP : iq_op_t'(wb_dat_i[2:0]);
	end

	// The queue count can only shrink between the ack decision and the push
	a_push_not_full: assert property (@(posedge clk) disable iff (!arst_n)
		push |-> !full);

endmodule

/* src/iq_queue.sv */
/*
 * Circular issue queue with issue and writeback updates
 * and an in-order Wishbone classic commit master
 */
`timescale 1ns/1ps
`include "iq_macros.svh"

module iq_queue (
	input  logic clk,
	input  logic arst_n,
	input  logic push,
	input  iq_pkg::iq_op_t push_op,
	input  logic [`DATA_W-1:0] push_a,
	input  logic [`DATA_W-1:0] push_b,
	output logic full,
	output iq_pkg::iq_entry_t [`QENTRIES-1:0] entries,
	output iq_pkg::que_ndx_t head,
	fpu_issue_if.src iss,
	fpu_wb_if.queue wb,
	output logic ret_cyc,
	output logic ret_stb,
	output logic ret_we,
	output logic [1:0] ret_adr,
	output logic [`DATA_W-1:0] ret_dat,
	input  logic ret_ack
);
	import iq_pkg::*;

	// Retire kinds placed on ret_adr
	localparam logic [1:0] RET_FPU = 2'd0;
	localparam logic [1:0] RET_NOP = 2'd1;
	localparam logic [1:0] RET_SYNC = 2'd2;

	// Per-entry state bits
	que_bitmask_t ent_v, ent_fpu, ent_sync, ent_issued, ent_done;
	// Entry payload RAM
	iq_op_t ent_op [`QENTRIES];
	logic [`DATA_W-1:0] ent_a [`QENTRIES];
	logic [`DATA_W-1:0] ent_b [`QENTRIES];
	logic [`DATA_W-1:0] ent_res [`QENTRIES];

	que_ndx_t tail;
	logic [`QNDX_W:0] count;
	logic push_fpu;
	logic iss_fire;
	logic wb_fire;
	logic retire;
	logic ret_load;

	assign full = (count == `QENTRIES);
	assign push_fpu = push_op inside {OP_FNEG, OP_FABS, OP_FMIN, OP_FMAX};
	assign iss_fire = iss.valid & iss.ready;
	// Dispatch owns the RAM write port whenever it pushes
	assign wb.accept = ~push;
	assign wb_fire = wb.valid & wb.accept;
	assign retire = ret_stb & ret_ack;
	// Head is ready to retire and the strobe has had its idle cycle
	assign ret_load = ~ret_stb & ent_v[head] & ent_done[head];
	assign ret_we = ret_cyc;

	// Operands for the execute unit come from the picked slot
	assign iss.op = ent_op[iss.ndx];
	assign iss.a = ent_a[iss.ndx];
	assign iss.b = ent_b[iss.ndx];

	always_comb begin
		for (int i = 0; i < `QENTRIES; i++) begin
			entries[i].v = ent_v[i];
			entries[i].fpu = ent_fpu[i];
			entries[i].sync = ent_sync[i];
			entries[i].issued = ent_issued[i];
			entries[i].done = ent_done[i];
			entries[i].op = ent_op[i];
			entries[i].a = ent_a[i];
			entries[i].b = ent_b[i];
			entries[i].res = ent_res[i];
		end
	end

	// ====================
	// Entry state
	// ====================

	// Push, issue, writeback and retire never address the same slot
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ent_v <= '0;
			ent_fpu <= '0;
			ent_sync <= '0;
			ent_issued <= '0;
			ent_done <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
			ret_cyc <= `FALSE;
			ret_stb <= `FALSE;
		end else begin
			if (push) begin
				ent_v[tail] <= `TRUE;
				ent_fpu[tail] <= push_fpu;
				ent_sync[tail] <= (push_op == OP_SYNC);
				ent_issued[tail] <= `FALSE;
				// NOP and SYNC have no work and count as done at once
				ent_done[tail] <= ~push_fpu;
				tail <= tail + 1'b1;
			end
			if (iss_fire)
				ent_issued[iss.ndx] <= `TRUE;
			if (wb_fire)
				ent_done[wb.ndx] <= `TRUE;
			if (retire) begin
				ent_v[head] <= `FALSE;
				head <= head + 1'b1;
				ret_cyc <= `FALSE;
				ret_stb <= `FALSE;
			end else if (ret_load) begin
				ret_cyc <= `TRUE;
				ret_stb <= `TRUE;
			end
			count <= count + (`QNDX_W+1)'(push) - (`QNDX_W+1)'(retire);
		end
	end

	// ====================
	// Payload RAM and commit data
	// ====================

	always_ff @(posedge clk) begin
		if (push) begin
			ent_op[tail] <= push_op;
			ent_a[tail] <= push_a;
			ent_b[tail] <= push_b;
		end else if (wb_fire) begin
			ent_res[wb.ndx] <= wb.res;
		end
		if (push)
			ent_res[tail] <= '0;
		if (ret_load) begin
			ret_adr <= ent_fpu[head] ? RET_FPU : (ent_sync[head] ? RET_SYNC : RET_NOP);
			ret_dat <= ent_fpu[head] ? ent_res[head] : '0;
		end
	end

	// Results only land in slots waiting on the FPU
	a_wb_target: assert property (@(posedge clk) disable iff (!arst_n)
		wb_fire |-> ent_v[wb.ndx] && ent_issued[wb.ndx] && !ent_done[wb.ndx]);

	// The selector never picks a slot twice or an empty one
	a_iss_target: assert property (@(posedge clk) disable iff (!arst_n)
		iss_fire |-> ent_v[iss.ndx] && !ent_issued[iss.ndx]);

endmodule

/* src/fpu_issue_sel.sv */
/*
 * Oldest-first floating-point issue selector
 * FPU entries may not pass a valid SYNC while older work remains
 */
`timescale 1ns/1ps
`include "iq_macros.svh"

module fpu_issue_sel (
	input  iq_pkg::iq_entry_t [`QENTRIES-1:0] entries,
	input  iq_pkg::que_ndx_t head,
	fpu_issue_if.sel iss
);
	import iq_pkg::*;

	que_bitmask_t could_issue;
	que_ndx_t pos;
	que_ndx_t pick;
	logic found;
	// Set once a SYNC with older valid work has been walked past
	logic blocked;
	// Any valid entry between head and the current position
	logic older_v;

	// Candidates are waiting FPU entries
	always_comb begin
		for (int i = 0; i < `QENTRIES; i++)
			could_issue[i] = entries[i].v & entries[i].fpu & ~entries[i].issued;
	end

	// ====================
	// Walk from head
	// ====================

	// Position 0 is the oldest entry, the walk stops at the first legal pick
	always_comb begin
		found = `FALSE;
		blocked = `FALSE;
		older_v = `FALSE;
		pick = head;
		pos = head;
		for (int k = 0; k < `QENTRIES; k++) begin
			pos = head + que_ndx_t'(k);
			if (!found && !blocked && could_issue[pos]) begin
				found = `TRUE;
				pick = pos;
			end
			// A SYNC only bars younger entries while something older is valid
			if (entries[pos].v && entries[pos].sync && older_v)
				blocked = `TRUE;
			older_v = older_v | entries[pos].v;
		end
	end

	// Offer an entry only while the FPU can take it
	always_comb begin
		iss.valid = found & iss.ready;
		iss.ndx = pick;
	end

endmodule

/* src/fpu_exec.sv */
/*
 * Two-stage FPU for FNEG, FABS, FMIN and FMAX on IEEE-754 singles
 * Both stages hold while the queue refuses the writeback
 */
`timescale 1ns/1ps
`include "iq_macros.svh"

// Valid-tagged pipeline register, contents freeze while hold is high
module fpu_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic clk,
	input  logic arst_n,
	input  logic in_valid,
	input  payload_t in_data,
	input  logic hold,
	output logic out_valid,
	output payload_t out_data
);
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			out_valid <= `FALSE;
		else if (!hold)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid && !hold)
			out_data <= in_data;
	end
endmodule

module fpu_exec (
	input  logic clk,
	input  logic arst_n,
	fpu_issue_if.exe iss,
	fpu_wb_if.exe wb
);
	import iq_pkg::*;

	fpu_s1_t s1_in, s1;
	fpu_s2_t s2_in, s2;
	logic s1_valid, s2_valid;
	logic hold1, hold2;
	logic a_lt_b;

	// Stage 2 waits on the queue, stage 1 waits behind a full stage 2
	assign hold2 = s2_valid & ~wb.accept;
	assign hold1 = s1_valid & hold2;
	assign iss.ready = ~hold1;

	// ====================
	// Stage 1
	// ====================

	// Total order, so -0 sorts below +0
	always_comb begin
		if (iss.a[31] != iss.b[31])
			a_lt_b = iss.a[31];
		else if (!iss.a[31])
			a_lt_b = iss.a[30:0] < iss.b[30:0];
		else
			a_lt_b = iss.a[30:0] > iss.b[30:0];
		s1_in = '{ndx: iss.ndx, op: iss.op, a: iss.a, b: iss.b, a_lt_b: a_lt_b};
	end

	fpu_stage_reg #(.payload_t(fpu_s1_t)) u_s1 (
		.clk(clk), .arst_n(arst_n),
		.in_valid(iss.valid & iss.ready), .in_data(s1_in), .hold(hold1),
		.out_valid(s1_valid), .out_data(s1)
	);

	// ====================
	// Stage 2
	// ====================

	always_comb begin
		s2_in.ndx = s1.ndx;
		case (s1.op)
			OP_FNEG: s2_in.res = {~s1.a[31], s1.a[30:0]};
			OP_FABS: s2_in.res = {1'b0, s1.a[30:0]};
			OP_FMIN: s2_in.res = s1.a_lt_b ? s1.a : s1.b;
			OP_FMAX: s2_in.res = s1.a_lt_b ? s1.b : s1.a;
			default: s2_in.res = '0;
		endcase
	end

	fpu_stage_reg #(.payload_t(fpu_s2_t)) u_s2 (
		.clk(clk), .arst_n(arst_n),
		.in_valid(s1_valid), .in_data(s2_in), .hold(hold2),
		.out_valid(s2_valid), .out_data(s2)
	);

	assign wb.valid = s2_valid;
	assign wb.ndx = s2.ndx;
	assign wb.res = s2.res;

	// A refused result stays put until the queue takes it
	a_wb_stable: assert property (@(posedge clk) disable iff (!arst_n)
		wb.valid && !wb.accept |=> wb.valid && $stable(wb.ndx) && $stable(wb.res));

endmodule

/* src/iq_top.sv */
/*
 * Issue slice top level
 * Dispatch, issue queue, FPU selector and two-stage FPU
 */
`timescale 1ns/1ps
`include "iq_macros.svh"

module iq_top (
	input  logic clk,
	input  logic arst_n,
	// Command slave port
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [1:0] wb_adr,
	input  logic [`DATA_W-1:0] wb_dat_i,
	output logic wb_ack,
	// Retire master port
	output logic ret_cyc,
	output logic ret_stb,
	output logic ret_we,
	output logic [1:0] ret_adr,
	output logic [`DATA_W-1:0] ret_dat,
	input  logic ret_ack,
	// Issue trace for performance counters
	output logic fpu_issue,
	output iq_pkg::que_ndx_t fpu_issue_ndx
);
	import iq_pkg::*;

	logic full;
	logic push;
	iq_op_t push_op;
	logic [`DATA_W-1:0] push_a, push_b;
	iq_entry_t [`QENTRIES-1:0] entries;
	que_ndx_t head;

	fpu_issue_if u_iss_if ();
	fpu_wb_if u_wb_if ();

	iq_dispatch u_dispatch (
		.clk(clk), .arst_n(arst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
		.full(full), .push(push), .push_op(push_op),
		.push_a(push_a), .push_b(push_b)
	);

	iq_queue u_queue (
		.clk(clk), .arst_n(arst_n),
		.push(push), .push_op(push_op), .push_a(push_a), .push_b(push_b),
		.full(full), .entries(entries), .head(head),
		.iss(u_iss_if.src), .wb(u_wb_if.queue),
		.ret_cyc(ret_cyc), .ret_stb(ret_stb), .ret_we(ret_we),
		.ret_adr(ret_adr), .ret_dat(ret_dat), .ret_ack(ret_ack)
	);

	fpu_issue_sel u_sel (
		.entries(entries), .head(head), .iss(u_iss_if.sel)
	);

	fpu_exec u_exec (
		.clk(clk), .arst_n(arst_n),
		.iss(u_iss_if.exe), .wb(u_wb_if.exe)
	);

	// Fires on the issue handshake edge
	assign fpu_issue = u_iss_if.valid & u_iss_if.ready;
	assign fpu_issue_ndx = u_iss_if.ndx;

endmodule

/* test/tb_iq_top.sv */
/*
 * Testbench for the issue slice driven by a command table with delayed retire acks
 * An issue monitor checks order, single issue and the SYNC barrier
 */
`timescale 1ns/1ps
`include "iq_macros.svh"

module tb_iq_top;
	import iq_pkg::*;

	localparam int NROWS = 24;
	// Retire acks are held low this long after reset to fill the queue
	localparam int HOLD_CYCLES = 80;
	localparam logic [1:0] KIND_FPU = 2'd0;
	localparam logic [1:0] KIND_NOP = 2'd1;
	localparam logic [1:0] KIND_SYNC = 2'd2;

	// One command and what it must retire as
	typedef struct packed {
		iq_op_t op;
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		logic [1:0] kind;
		logic [`DATA_W-1:0] exp;
	} row_t;

	logic clk = 1'b0;
	logic arst_n;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	logic [1:0] wb_adr;
	logic [`DATA_W-1:0] wb_dat_i;
	logic ret_cyc, ret_stb, ret_we, ret_ack;
	logic [1:0] ret_adr;
	logic [`DATA_W-1:0] ret_dat;
	logic fpu_issue;
	que_ndx_t fpu_issue_ndx;

	row_t rows [NROWS];
	logic row_issued [NROWS];
	// Commands acked by dispatch, rows retired, FPU issues seen
	int acked = 0;
	int retired = 0;
	int issued = 0;
	int errors = 0;
	logic hold_ret;
	int unsigned lcg_state = 28;

	iq_top u_dut (
		.clk(clk), .arst_n(arst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
		.ret_cyc(ret_cyc), .ret_stb(ret_stb), .ret_we(ret_we),
		.ret_adr(ret_adr), .ret_dat(ret_dat), .ret_ack(ret_ack),
		.fpu_issue(fpu_issue), .fpu_issue_ndx(fpu_issue_ndx)
	);

	always #50 clk = ~clk;

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// ====================
	// Command table
	// ====================

	task automatic set_row(input int i, input iq_op_t op, input logic [31:0] a,
		input logic [31:0] b, input logic [1:0] kind, input logic [31:0] exp);
		rows[i] = '{op: op, a: a, b: b, kind: kind, exp: exp};
		row_issued[i] = 1'b0;
	endtask

	// Results follow the sign rules and the total order where -0 < +0
	task automatic fill_table();
		set_row(0, OP_FNEG, 32'h3F800000, 32'h5A5A0000, KIND_FPU, 32'hBF800000);
		set_row(1, OP_FABS, 32'hC0400000, 32'h5A5A0001, KIND_FPU, 32'h40400000);
		set_row(2, OP_FMIN, 32'h3F800000, 32'hC0000000, KIND_FPU, 32'hC0000000);
		set_row(3, OP_FMAX, 32'h3F800000, 32'hC0000000, KIND_FPU, 32'h3F800000);
		set_row(4, OP_SYNC, 32'h0, 32'h0, KIND_SYNC, 32'h0);
		set_row(5, OP_FMIN, 32'h00000000, 32'h80000000, KIND_FPU, 32'h80000000);
		set_row(6, OP_FMAX, 32'h80000000, 32'h00000000, KIND_FPU, 32'h00000000);
		set_row(7, OP_NOP, 32'h1234, 32'h5678, KIND_NOP, 32'h0);
		set_row(8, OP_FMIN, 32'hBF800000, 32'hC0000000, KIND_FPU, 32'hC0000000);
		set_row(9, OP_FMAX, 32'hBF800000, 32'hC0000000, KIND_FPU, 32'hBF800000);
		set_row(10, OP_FNEG, 32'h80000000, 32'h5A5A0002, KIND_FPU, 32'h00000000);
		set_row(11, OP_FABS, 32'h80000000, 32'h5A5A0003, KIND_FPU, 32'h00000000);
		set_row(12, OP_SYNC, 32'h0, 32'h0, KIND_SYNC, 32'h0);
		set_row(13, OP_FMIN, 32'h40400000, 32'h3FC00000, KIND_FPU, 32'h3FC00000);
		set_row(14, OP_FMAX, 32'h3F000000, 32'h42C80000, KIND_FPU, 32'h42C80000);
		set_row(15, OP_FMIN, 32'hC2C80000, 32'hBF000000, KIND_FPU, 32'hC2C80000);
		set_row(16, OP_FNEG, 32'h42C80000, 32'h5A5A0004, KIND_FPU, 32'hC2C80000);
		set_row(17, OP_SYNC, 32'h0, 32'h0, KIND_SYNC, 32'h0);
		set_row(18, OP_SYNC, 32'h0, 32'h0, KIND_SYNC, 32'h0);
		set_row(19, OP_FMAX, 32'hFF800000, 32'h7F800000, KIND_FPU, 32'h7F800000);
		set_row(20, OP_FMIN, 32'h00000001, 32'h80000001, KIND_FPU, 32'h80000001);
		set_row(21, OP_NOP, 32'h0, 32'h0, KIND_NOP, 32'h0);
		set_row(22, OP_FABS, 32'hBFC00000, 32'h5A5A0005, KIND_FPU, 32'h3FC00000);
		set_row(23, OP_FMIN, 32'h3FC00000, 32'h3FC00000, KIND_FPU, 32'h3FC00000);
	endtask

	function automatic int count_fpu_rows();
		int n;
		n = 0;
		for (int i = 0; i < NROWS; i++)
			if (rows[i].kind == KIND_FPU)
				n++;
		return n;
	endfunction

	// ====================
	// Command side
	// ====================

	// Called 5 ns after an edge and returns 5 ns after the ack edge
	task automatic bus_write(input logic [1:0] adr, input logic [`DATA_W-1:0] dat);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat_i = dat;
		@(posedge clk);
		#5;
		// A full queue withholds the ack on the command register
		while (!wb_ack) begin
			@(posedge clk);
			#5;
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic send_rows();
		for (int r = 0; r < NROWS; r++) begin
			bus_write(2'd0, rows[r].a);
			bus_write(2'd1, rows[r].b);
			bus_write(2'd2, {29'd0, rows[r].op});
			acked++;
			assert (acked - retired <= `QENTRIES) else begin
				$display("** Error @ %0t ns: %0d commands in flight, queue holds only %0d",
					$time, acked - retired, `QENTRIES);
				errors++;
			end
		end
	endtask

	// Ends the back-pressure phase once the queue must have filled up
	task automatic release_retire();
		repeat (HOLD_CYCLES) @(posedge clk);
		@(negedge clk);
		assert (acked - retired == `QENTRIES) else begin
			$display("** Error @ %0t ns: %0d commands in flight at end of stall, expected %0d",
				$time, acked - retired, `QENTRIES);
			errors++;
		end
		hold_ret = 1'b0;
	endtask

	// ====================
	// Issue monitor
	// ====================

	// Row r sits in queue slot r mod 8 while it is between acked and retired
	task automatic check_issue(input que_ndx_t ndx);
		int hit;
		hit = -1;
		for (int r = retired; r < acked; r++)
			if ((r % `QENTRIES) == int'(ndx))
				hit = r;
		assert (hit >= 0) else begin
			$display("** Error @ %0t ns: issue of slot %0d, which holds no queued row",
				$time, ndx);
			errors++;
		end
		if (hit >= 0) begin
			assert (rows[hit].kind == KIND_FPU) else begin
				$display("** Error @ %0t ns: row %0d issued but is not an FPU row", $time, hit);
				errors++;
			end
			assert (!row_issued[hit]) else begin
				$display("Row %0d was issued a second time at %0t ns", hit, $time);
				errors++;
			end
			// A SYNC with unretired older rows bars everything younger
			for (int s = retired + 1; s < hit; s++)
				assert (rows[s].op != OP_SYNC) else begin
					$display("** Error @ %0t ns: row %0d issued past SYNC row %0d",
						$time, hit, s);
					errors++;
				end
			row_issued[hit] = 1'b1;
			issued++;
		end
	endtask

	always @(negedge clk) begin
		if (arst_n && fpu_issue)
			check_issue(fpu_issue_ndx);
	end

	// ====================
	// Retire side
	// ====================

	initial begin : scoreboard
		int unsigned delay;
		int r;
		forever begin
			@(posedge clk);
			#5;
			if (ret_stb && !ret_ack) begin
				delay = lcg_next() % 6;
				repeat (delay) begin
					@(posedge clk);
					#5;
				end
				while (hold_ret) begin
					@(posedge clk);
					#5;
				end
				r = retired;
				// The retire write stays on the bus until it is acked
				assert (ret_cyc && ret_stb && ret_we) else begin
					$display("** Error @ %0t ns: retire cycle dropped, cyc %b stb %b we %b",
						$time, ret_cyc, ret_stb, ret_we);
					errors++;
				end
				assert (r < NROWS) else begin
					$display("A retirement appeared after all %0d rows had retired", NROWS);
					errors++;
				end
				if (r < NROWS) begin
					assert (ret_adr == rows[r].kind) else begin
						$display("** Error @ %0t ns: row %0d retired as kind %0d, expected %0d",
							$time, r, ret_adr, rows[r].kind);
						errors++;
					end
					assert (ret_dat == rows[r].exp) else begin
						$display("** Error @ %0t ns: row %0d retired data %h, expected %h",
							$time, r, ret_dat, rows[r].exp);
						errors++;
					end
					if (rows[r].kind == KIND_FPU)
						assert (row_issued[r]) else begin
							$display("Row %0d retired without ever being issued", r);
							errors++;
						end
				end
				ret_ack = 1'b1;
				@(posedge clk);
				#5;
				ret_ack = 1'b0;
				retired++;
				// Strobe must drop for a cycle between retirements
				assert (!ret_stb) else begin
					$display("** Error @ %0t ns: retire strobe still high after the ack edge",
						$time);
					errors++;
				end
			end
		end
	end

	// ====================
	// Main sequence
	// ====================

	initial begin : main
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 2'd0;
		wb_dat_i = '0;
		ret_ack = 1'b0;
		hold_ret = 1'b1;
		arst_n = 1'b0;
		fill_table();
		repeat (8) @(posedge clk);
		#5;
		arst_n = 1'b1;
		assert (!wb_ack && !ret_cyc && !ret_stb && !fpu_issue) else begin
			$display("** Error @ %0t ns: bus or issue outputs active right after reset", $time);
			errors++;
		end
		fork
			send_rows();
			release_retire();
		join
		wait (retired == NROWS);
		repeat (4) @(posedge clk);
		assert (issued == count_fpu_rows()) else begin
			$display("** Error @ %0t ns: %0d FPU issues seen, expected %0d",
				$time, issued, count_fpu_rows());
			errors++;
		end
		$display("Summary: %0d rows retired, %0d FPU issues, %0d errors",
			retired, issued, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Twelve cycles per row covers three bus writes and a slow retire
	initial begin : watchdog
		repeat (NROWS * 12 + 100) @(posedge clk);
		$display("Timeout, the run did not finish within %0d clock cycles", NROWS * 12 + 100);
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* flist.f */
+incdir+src
src/iq_pkg.sv
src/iq_intf.sv
src/iq_dispatch.sv
src/iq_queue.sv
src/fpu_issue_sel.sv
src/fpu_exec.sv
src/iq_top.sv
test/tb_iq_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile the issue slice with Verilator and run the testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_iq_top -f flist.f -o tb_iq_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_iq_top > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
	echo "No result line found in $LOG"
	exit 1
fi
exit 0
